// File: rtl/vga_dac_pkg.sv
// Shared constants for the VGA palette block.
// Imported by the CPU port controller, the register file and the top level.
package vga_dac_pkg;

  // Colour component and palette index width
  localparam int color_w = 8;

  // Palette entries, one per 8-bit pixel index
  localparam int palette_depth = 256;

  // CPU register address codes
  // Pixel mask, ANDed with every incoming pixel index
  localparam logic [1:0] addr_mask        = 2'd0;
  // Read index, sets the start entry for data register reads
  localparam logic [1:0] addr_read_index  = 2'd1;
  // Write index, sets the start entry for data register writes
  localparam logic [1:0] addr_write_index = 2'd2;
  // Data register, steps through red, green, blue
  localparam logic [1:0] addr_data        = 2'd3;

  // Component cycle codes
  // Order of access on the data register
  localparam logic [1:0] comp_red   = 2'd0;
  localparam logic [1:0] comp_green = 2'd1;
  localparam logic [1:0] comp_blue  = 2'd2;
  // Code 3 is unused and reads back as zero

endpackage

// File: rtl/vga_dac_regs.sv
// Palette storage, three 256 x 8 arrays for red, green and blue.
// One registered video read port, one registered CPU read port, one CPU write port.
module vga_dac_regs (
  input  logic                            clk,

  // Video lookup side
  input  logic [vga_dac_pkg::color_w-1:0] index,
  output logic [vga_dac_pkg::color_w-1:0] red,
  output logic [vga_dac_pkg::color_w-1:0] green,
  output logic [vga_dac_pkg::color_w-1:0] blue,

  // CPU write strobe
  input  logic                            write,

  // CPU read side
  input  logic [1:0]                      read_data_cycle,
  input  logic [vga_dac_pkg::color_w-1:0] read_data_register,
  output logic [vga_dac_pkg::color_w-1:0] read_data,

  // CPU write side
  input  logic [1:0]                      write_data_cycle,
  input  logic [vga_dac_pkg::color_w-1:0] write_data_register,
  input  logic [vga_dac_pkg::color_w-1:0] write_data
);
  import vga_dac_pkg::*;

  // Component arrays, contents undefined until written
  logic [color_w-1:0] red_dac   [palette_depth];
  logic [color_w-1:0] green_dac [palette_depth];
  logic [color_w-1:0] blue_dac  [palette_depth];

  // Video lookup, all three components in one cycle
  always_ff @(posedge clk)
  begin
    red   <= red_dac[index];
    green <= green_dac[index];
    blue  <= blue_dac[index];
  end

  // CPU read, one component picked by the cycle code
  always_ff @(posedge clk)
  begin
    case (read_data_cycle)
      comp_red:   read_data <= red_dac[read_data_register];
      comp_green: read_data <= green_dac[read_data_register];
      comp_blue:  read_data <= blue_dac[read_data_register];
      default:    read_data <= '0;
    endcase
  end

  // CPU write, one component per strobe
  // Visible to reads from the next cycle on
  always_ff @(posedge clk)
  begin
    if (write)
    begin
      case (write_data_cycle)
        comp_red:   red_dac[write_data_register]   <= write_data;
        comp_green: green_dac[write_data_register] <= write_data;
        comp_blue:  blue_dac[write_data_register]  <= write_data;
        default:    ;
      endcase
    end
  end

endmodule

// File: rtl/vga_dac_port.sv
// CPU register port of the palette block, VGA DAC style.
// Decodes mask, read index, write index and data; sequences R, G, B per entry.
module vga_dac_port (
  input  logic                            clk,
  input  logic                            reset,

  // CPU bus
  input  logic [1:0]                      cpu_addr,
  input  logic                            cpu_wr,
  input  logic                            cpu_rd,
  input  logic [vga_dac_pkg::color_w-1:0] cpu_wdata,
  output logic [vga_dac_pkg::color_w-1:0] cpu_rdata,
  output logic                            cpu_rdata_valid,

  // Mask towards the pixel pipeline
  output logic [vga_dac_pkg::color_w-1:0] pixel_mask,

  // Palette write port
  output logic                            pal_write,
  output logic [1:0]                      pal_write_cycle,
  output logic [vga_dac_pkg::color_w-1:0] pal_write_index,
  output logic [vga_dac_pkg::color_w-1:0] pal_write_data,

  // Palette read port
  output logic [1:0]                      pal_read_cycle,
  output logic [vga_dac_pkg::color_w-1:0] pal_read_index,
  input  logic [vga_dac_pkg::color_w-1:0] pal_read_data
);
  import vga_dac_pkg::*;

  // Index and component state, one pair per direction
  logic [color_w-1:0] read_index;
  logic [1:0]         read_cycle;
  logic [color_w-1:0] write_index;
  logic [1:0]         write_cycle;

  // Decoded register accesses
  logic wr_mask;
  logic wr_read_index;
  logic wr_write_index;
  logic wr_data;
  logic rd_data;

  // Read return path
  logic               rdata_from_pal;
  logic [color_w-1:0] rdata_reg;

  // Red, green, blue, then back to red
  function automatic logic [1:0] next_cycle(input logic [1:0] cycle);
    if (cycle == comp_blue)
      return comp_red;
    else
      return cycle + 2'd1;
  endfunction

  // Register decode
  assign wr_mask        = cpu_wr && (cpu_addr == addr_mask);
  assign wr_read_index  = cpu_wr && (cpu_addr == addr_read_index);
  assign wr_write_index = cpu_wr && (cpu_addr == addr_write_index);
  assign wr_data        = cpu_wr && (cpu_addr == addr_data);
  assign rd_data        = cpu_rd && (cpu_addr == addr_data);

  // Pixel mask, all ones out of reset
  always_ff @(posedge clk)
  begin
    if (reset)
      pixel_mask <= 8'hff;
    else if (wr_mask)
      pixel_mask <= cpu_wdata;
  end

  // Write index and write component
  // Index steps once the blue component is written
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      write_index <= '0;
      write_cycle <= comp_red;
    end
    else if (wr_write_index)
    begin
      write_index <= cpu_wdata;
      write_cycle <= comp_red;
    end
    else if (wr_data)
    begin
      write_cycle <= next_cycle(write_cycle);
      // Wraps 255 -> 0 by width
      if (write_cycle == comp_blue)
        write_index <= write_index + 1'b1;
    end
  end

  // Read index and read component, same rule as the write side
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      read_index <= '0;
      read_cycle <= comp_red;
    end
    else if (wr_read_index)
    begin
      read_index <= cpu_wdata;
      read_cycle <= comp_red;
    end
    else if (rd_data)
    begin
      read_cycle <= next_cycle(read_cycle);
      if (read_cycle == comp_blue)
        read_index <= read_index + 1'b1;
    end
  end

  // Palette write goes straight through in the access cycle
  assign pal_write       = wr_data;
  assign pal_write_cycle = write_cycle;
  assign pal_write_index = write_index;
  assign pal_write_data  = cpu_wdata;

  // Palette read address from current state
  // Register file returns the component one cycle later
  assign pal_read_cycle = read_cycle;
  assign pal_read_index = read_index;

  // One-cycle read response strobe and source select
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cpu_rdata_valid <= 1'b0;
      rdata_from_pal  <= 1'b0;
    end
    else
    begin
      cpu_rdata_valid <= cpu_rd;
      rdata_from_pal  <= rd_data;
    end
  end

  // Latched value for the non-palette registers
  always_ff @(posedge clk)
  begin
    if (cpu_rd)
    begin
      case (cpu_addr)
        addr_mask:        rdata_reg <= pixel_mask;
        addr_read_index:  rdata_reg <= read_index;
        addr_write_index: rdata_reg <= write_index;
        default:          rdata_reg <= '0;
      endcase
    end
  end

  // Data reads come from the palette port
  assign cpu_rdata = rdata_from_pal ? pal_read_data : rdata_reg;

endmodule

// File: rtl/vga_dac_pixel_pipe.sv
// Pixel path of the palette block: mask, lookup and credit flow control.
// Output colours appear two cycles after a pixel is accepted.
module vga_dac_pixel_pipe #(
  // Sink buffer depth, 1 to 15
  parameter int num_credits = 4
) (
  input  logic                            clk,
  input  logic                            reset,

  // Pixel source
  input  logic                            pix_valid,
  input  logic [vga_dac_pkg::color_w-1:0] pix_index,
  output logic                            pix_ready,

  // Mask from the CPU port
  input  logic [vga_dac_pkg::color_w-1:0] pixel_mask,

  // Palette lookup
  output logic [vga_dac_pkg::color_w-1:0] lut_index,
  input  logic [vga_dac_pkg::color_w-1:0] lut_red,
  input  logic [vga_dac_pkg::color_w-1:0] lut_green,
  input  logic [vga_dac_pkg::color_w-1:0] lut_blue,

  // Display sink
  output logic                            out_valid,
  output logic [vga_dac_pkg::color_w-1:0] out_red,
  output logic [vga_dac_pkg::color_w-1:0] out_green,
  output logic [vga_dac_pkg::color_w-1:0] out_blue,
  input  logic                            out_credit
);

  // Wide enough to hold num_credits itself
  localparam int credit_w = $clog2(num_credits + 1);

  // Free slots in the sink buffer
  logic [credit_w-1:0] credits;

  // Pixel taken this cycle
  logic accept;

  // Stage one valid, lut_index holds a pixel
  logic lookup_valid;

  // Source may send while the sink has room
  assign pix_ready = (credits != '0);
  assign accept    = pix_valid && pix_ready;

  // Credit counter
  // Acceptance takes one, a returned credit gives one back
  // Both in one cycle leaves the count unchanged
  always_ff @(posedge clk)
  begin
    if (reset)
      credits <= credit_w'(num_credits);
    else if (accept && !out_credit)
      credits <= credits - 1'b1;
    else if (!accept && out_credit)
      credits <= credits + 1'b1;
  end

  // Stage one, masked index
  // Mask sampled at acceptance
  always_ff @(posedge clk)
  begin
    if (accept)
      lut_index <= pix_index & pixel_mask;
  end

  // Valid shift register following the two data stages
  // Stage two data is the registered palette read
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lookup_valid <= 1'b0;
      out_valid    <= 1'b0;
    end
    else
    begin
      lookup_valid <= accept;
      out_valid    <= lookup_valid;
    end
  end

  // Colours straight from the palette read registers
  // Meaningful only with out_valid
  assign out_red   = lut_red;
  assign out_green = lut_green;
  assign out_blue  = lut_blue;

endmodule

// File: rtl/vga_dac_top.sv
// Palette block top level, CPU register port plus pixel lookup path.
// Joins the port controller, the pixel pipeline and the palette register file.
module vga_dac_top #(
  // Sink buffer depth
  parameter int num_credits = 4
) (
  input  logic                            clk,
  input  logic                            reset,

  // CPU bus
  input  logic [1:0]                      cpu_addr,
  input  logic                            cpu_wr,
  input  logic                            cpu_rd,
  input  logic [vga_dac_pkg::color_w-1:0] cpu_wdata,
  output logic [vga_dac_pkg::color_w-1:0] cpu_rdata,
  output logic                            cpu_rdata_valid,

  // Pixel source
  input  logic                            pix_valid,
  input  logic [vga_dac_pkg::color_w-1:0] pix_index,
  output logic                            pix_ready,

  // Display sink
  output logic                            out_valid,
  output logic [vga_dac_pkg::color_w-1:0] out_red,
  output logic [vga_dac_pkg::color_w-1:0] out_green,
  output logic [vga_dac_pkg::color_w-1:0] out_blue,
  input  logic                            out_credit
);
  import vga_dac_pkg::*;

  // Mask from port to pipeline
  logic [color_w-1:0] pixel_mask;

  // CPU side of the palette
  logic               pal_write;
  logic [1:0]         pal_write_cycle;
  logic [color_w-1:0] pal_write_index;
  logic [color_w-1:0] pal_write_data;
  logic [1:0]         pal_read_cycle;
  logic [color_w-1:0] pal_read_index;
  logic [color_w-1:0] pal_read_data;

  // Video side of the palette
  logic [color_w-1:0] lut_index;
  logic [color_w-1:0] lut_red;
  logic [color_w-1:0] lut_green;
  logic [color_w-1:0] lut_blue;

  vga_dac_port u_port (
    .clk             (clk),
    .reset           (reset),
    .cpu_addr        (cpu_addr),
    .cpu_wr          (cpu_wr),
    .cpu_rd          (cpu_rd),
    .cpu_wdata       (cpu_wdata),
    .cpu_rdata       (cpu_rdata),
    .cpu_rdata_valid (cpu_rdata_valid),
    .pixel_mask      (pixel_mask),
    .pal_write       (pal_write),
    .pal_write_cycle (pal_write_cycle),
    .pal_write_index (pal_write_index),
    .pal_write_data  (pal_write_data),
    .pal_read_cycle  (pal_read_cycle),
    .pal_read_index  (pal_read_index),
    .pal_read_data   (pal_read_data)
  );

  vga_dac_pixel_pipe #(
    .num_credits (num_credits)
  ) u_pixel_pipe (
    .clk        (clk),
    .reset      (reset),
    .pix_valid  (pix_valid),
    .pix_index  (pix_index),
    .pix_ready  (pix_ready),
    .pixel_mask (pixel_mask),
    .lut_index  (lut_index),
    .lut_red    (lut_red),
    .lut_green  (lut_green),
    .lut_blue   (lut_blue),
    .out_valid  (out_valid),
    .out_red    (out_red),
    .out_green  (out_green),
    .out_blue   (out_blue),
    .out_credit (out_credit)
  );

  vga_dac_regs u_regs (
    .clk                 (clk),
    .index               (lut_index),
    .red                 (lut_red),
    .green               (lut_green),
    .blue                (lut_blue),
    .write               (pal_write),
    .read_data_cycle     (pal_read_cycle),
    .read_data_register  (pal_read_index),
    .read_data           (pal_read_data),
    .write_data_cycle    (pal_write_cycle),
    .write_data_register (pal_write_index),
    .write_data          (pal_write_data)
  );

endmodule

// File: verif/vga_dac_assert.sv
// Checker bound into the palette top level, shadow palette and pixel-side assertions.
// Counts assertion failures in fail_count for the testbench summary.
module vga_dac_assert #(
  parameter int num_credits = 4
) (
  input logic                            clk,
  input logic                            reset,
  input logic [1:0]                      cpu_addr,
  input logic                            cpu_wr,
  input logic                            cpu_rd,
  input logic [vga_dac_pkg::color_w-1:0] cpu_wdata,
  input logic                            cpu_rdata_valid,
  input logic                            pix_valid,
  input logic [vga_dac_pkg::color_w-1:0] pix_index,
  input logic                            pix_ready,
  input logic                            out_valid,
  input logic [vga_dac_pkg::color_w-1:0] out_red,
  input logic [vga_dac_pkg::color_w-1:0] out_green,
  input logic [vga_dac_pkg::color_w-1:0] out_blue,
  input logic                            out_credit
);
  import vga_dac_pkg::*;

  // Shadow of the palette and the write side of the port
  logic [color_w-1:0] shadow_red   [palette_depth];
  logic [color_w-1:0] shadow_green [palette_depth];
  logic [color_w-1:0] shadow_blue  [palette_depth];
  logic [color_w-1:0] shadow_mask;
  logic [color_w-1:0] shadow_windex;
  logic [1:0]         shadow_wcycle;

  // Expected lookup, one stage per pipeline stage
  logic [color_w-1:0] exp_index;
  logic [color_w-1:0] exp_red;
  logic [color_w-1:0] exp_green;
  logic [color_w-1:0] exp_blue;

  logic accept;
  int   outstanding;
  int   fail_count;

  initial fail_count = 0;

  assign accept = pix_valid && pix_ready;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      shadow_mask   <= 8'hff;
      shadow_windex <= '0;
      shadow_wcycle <= comp_red;
    end
    else if (cpu_wr && cpu_addr == addr_mask)
      shadow_mask <= cpu_wdata;
    else if (cpu_wr && cpu_addr == addr_write_index)
    begin
      shadow_windex <= cpu_wdata;
      shadow_wcycle <= comp_red;
    end
    else if (cpu_wr && cpu_addr == addr_data)
    begin
      // Entry complete after blue
      if (shadow_wcycle == comp_blue)
      begin
        shadow_wcycle <= comp_red;
        shadow_windex <= shadow_windex + 8'd1;
      end
      else
        shadow_wcycle <= shadow_wcycle + 2'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset && cpu_wr && cpu_addr == addr_data)
    begin
      case (shadow_wcycle)
        comp_red:   shadow_red[shadow_windex]   <= cpu_wdata;
        comp_green: shadow_green[shadow_windex] <= cpu_wdata;
        comp_blue:  shadow_blue[shadow_windex]  <= cpu_wdata;
        default:    ;
      endcase
    end
  end

  // Mask at acceptance, palette state one cycle later
  always_ff @(posedge clk)
  begin
    if (accept)
      exp_index <= pix_index & shadow_mask;
    exp_red   <= shadow_red[exp_index];
    exp_green <= shadow_green[exp_index];
    exp_blue  <= shadow_blue[exp_index];
  end

  // Pixels accepted and not yet credited back
  always_ff @(posedge clk)
  begin
    if (reset)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(accept) - int'(out_credit);
  end

  a_reset_idle: assert property (@(posedge clk) reset |=> !out_valid && !cpu_rdata_valid)
    else begin $error("output strobe high right after reset"); fail_count++; end

  a_rdata_strobe: assert property (@(posedge clk) disable iff (reset)
    cpu_rdata_valid == $past(cpu_rd))
    else begin $error("cpu_rdata_valid not one cycle after a read"); fail_count++; end

  a_out_strobe: assert property (@(posedge clk) disable iff (reset)
    out_valid == $past(accept, 2))
    else begin $error("out_valid not two cycles after acceptance"); fail_count++; end

  a_out_colour: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> (out_red == exp_red && out_green == exp_green && out_blue == exp_blue))
    else begin $error("pixel colour differs from the shadow palette"); fail_count++; end

  a_credit_limit: assert property (@(posedge clk) disable iff (reset)
    outstanding >= 0 && outstanding <= num_credits)
    else begin $error("outstanding pixels outside the credit range"); fail_count++; end

  a_ready_rule: assert property (@(posedge clk) disable iff (reset)
    pix_ready == (outstanding < num_credits))
    else begin $error("pix_ready does not follow the credit count"); fail_count++; end

endmodule

bind vga_dac_top vga_dac_assert #(
  .num_credits (num_credits)
) u_assert (
  .clk             (clk),
  .reset           (reset),
  .cpu_addr        (cpu_addr),
  .cpu_wr          (cpu_wr),
  .cpu_rd          (cpu_rd),
  .cpu_wdata       (cpu_wdata),
  .cpu_rdata_valid (cpu_rdata_valid),
  .pix_valid       (pix_valid),
  .pix_index       (pix_index),
  .pix_ready       (pix_ready),
  .out_valid       (out_valid),
  .out_red         (out_red),
  .out_green       (out_green),
  .out_blue        (out_blue),
  .out_credit      (out_credit)
);

// File: verif/vga_dac_tb.sv
// Testbench for the palette block with CPU register traffic and a credit-returning sink.
// CPU readback is checked here against a palette model and the pixel side by the bound checker.
module vga_dac_tb;
  import vga_dac_pkg::*;

  localparam int num_credits = 4;
  // Roughly twice the 780 fill, 150 readback and 800 pixel stream cycles
  localparam int cycle_limit = 4000;

  logic               clk;
  logic               reset;
  logic [1:0]         cpu_addr;
  logic               cpu_wr;
  logic               cpu_rd;
  logic [color_w-1:0] cpu_wdata;
  logic [color_w-1:0] cpu_rdata;
  logic               cpu_rdata_valid;
  logic               pix_valid;
  logic [color_w-1:0] pix_index;
  logic               pix_ready;
  logic               out_valid;
  logic [color_w-1:0] out_red;
  logic [color_w-1:0] out_green;
  logic [color_w-1:0] out_blue;
  logic               out_credit;

  // Palette model with one array per component
  logic [color_w-1:0] model_red   [palette_depth];
  logic [color_w-1:0] model_green [palette_depth];
  logic [color_w-1:0] model_blue  [palette_depth];

  integer seed;
  int     cycles;
  int     mismatches;
  int     tests_run;
  int     tests_failed;
  int     sent;
  int     received;
  // Sink buffer fill and length of the current credit stall
  int     sink_held;
  int     sink_hold;

  vga_dac_top #(
    .num_credits (num_credits)
  ) DUT (
    .clk             (clk),
    .reset           (reset),
    .cpu_addr        (cpu_addr),
    .cpu_wr          (cpu_wr),
    .cpu_rd          (cpu_rd),
    .cpu_wdata       (cpu_wdata),
    .cpu_rdata       (cpu_rdata),
    .cpu_rdata_valid (cpu_rdata_valid),
    .pix_valid       (pix_valid),
    .pix_index       (pix_index),
    .pix_ready       (pix_ready),
    .out_valid       (out_valid),
    .out_red         (out_red),
    .out_green       (out_green),
    .out_blue        (out_blue),
    .out_credit      (out_credit)
  );

  always #2 clk = ~clk;

  // Run length guard
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("test failed");
      $finish;
    end
  end

  // Display sink frees buffered pixels unless stalled
  always @(posedge clk)
  begin
    #1;
    if (reset)
    begin
      out_credit = 1'b0;
      sink_held  = 0;
      sink_hold  = 0;
    end
    else
    begin
      if (out_valid)
      begin
        sink_held++;
        received++;
      end
      out_credit = 1'b0;
      if (sink_hold > 0)
        sink_hold--;
      else if (({$random(seed)} % 8) == 0)
        sink_hold = {$random(seed)} % 12;
      else if (sink_held > 0)
      begin
        out_credit = 1'b1;
        sink_held--;
      end
    end
  end

  // Tasks start and end just after a rising edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic cpu_write(input logic [1:0] addr, input logic [color_w-1:0] data);
    cpu_addr  = addr;
    cpu_wdata = data;
    cpu_wr    = 1'b1;
    step_cycle();
    cpu_wr    = 1'b0;
  endtask

  task automatic cpu_read(input logic [1:0] addr, output logic [color_w-1:0] data);
    cpu_addr = addr;
    cpu_rd   = 1'b1;
    step_cycle();
    cpu_rd   = 1'b0;
    while (!cpu_rdata_valid)
      step_cycle();
    data = cpu_rdata;
  endtask

  task automatic check_byte(input logic [1:0] addr, input logic [color_w-1:0] expected,
                            input string what);
    logic [color_w-1:0] got;
    cpu_read(addr, got);
    if (got !== expected)
    begin
      mismatches++;
      $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, expected);
    end
  endtask

  // Three data reads starting with red
  task automatic check_entry(input logic [color_w-1:0] idx);
    check_byte(addr_data, model_red[idx], "red");
    check_byte(addr_data, model_green[idx], "green");
    check_byte(addr_data, model_blue[idx], "blue");
  endtask

  // Random triple at the current write index
  task automatic write_components(input logic [color_w-1:0] idx);
    model_red[idx]   = 8'($random(seed));
    model_green[idx] = 8'($random(seed));
    model_blue[idx]  = 8'($random(seed));
    cpu_write(addr_data, model_red[idx]);
    cpu_write(addr_data, model_green[idx]);
    cpu_write(addr_data, model_blue[idx]);
  endtask

  task automatic send_pixels(input int count);
    logic taken;
    for (int n = 0; n < count; n++)
    begin
      // Occasional idle cycle on the source
      if (({$random(seed)} % 4) == 0)
        step_cycle();
      pix_valid = 1'b1;
      pix_index = 8'($random(seed));
      do
      begin
        taken = pix_ready;
        step_cycle();
      end while (!taken);
      pix_valid = 1'b0;
      sent++;
    end
  endtask

  function automatic int error_total();
    return mismatches + DUT.u_assert.fail_count;
  endfunction

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_total() == errs_before)
      $display("%s: ok", name);
    else
    begin
      tests_failed++;
      $display("%s: %0d errors", name, error_total() - errs_before);
    end
  endtask

  initial
  begin
    logic [color_w-1:0] picked [16];
    int errs;
    seed = 32'hfb02_d38a;
    clk = 1'b0;
    reset = 1'b1;
    cpu_addr = addr_mask;
    cpu_wr = 1'b0;
    cpu_rd = 1'b0;
    cpu_wdata = '0;
    pix_valid = 1'b0;
    pix_index = '0;
    out_credit = 1'b0;
    cycles = 0;
    mismatches = 0;
    tests_run = 0;
    tests_failed = 0;
    sent = 0;
    received = 0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Register defaults after a few idle cycles
    errs = error_total();
    repeat (4) step_cycle();
    check_byte(addr_mask, 8'hff, "mask");
    check_byte(addr_read_index, 8'd0, "read index");
    check_byte(addr_write_index, 8'd0, "write index");
    report_test("reset_state", errs);

    // Whole palette from entry 0 and one more triple that wraps onto entry 0
    errs = error_total();
    cpu_write(addr_write_index, 8'd0);
    for (int i = 0; i < palette_depth; i++)
      write_components(8'(i));
    write_components(8'd0);
    check_byte(addr_write_index, 8'd1, "write index");
    cpu_write(addr_read_index, 8'd255);
    check_entry(8'd255);
    check_entry(8'd0);
    check_byte(addr_read_index, 8'd1, "read index");
    report_test("fill_and_wrap", errs);

    // Random entries read back in order of writing
    errs = error_total();
    for (int k = 0; k < 16; k++)
    begin
      picked[k] = 8'($random(seed));
      cpu_write(addr_write_index, picked[k]);
      write_components(picked[k]);
    end
    for (int k = 0; k < 16; k++)
    begin
      cpu_write(addr_read_index, picked[k]);
      check_entry(picked[k]);
      check_byte(addr_read_index, picked[k] + 8'd1, "read index");
    end
    report_test("random_readback", errs);

    // Pixel stream under credit stalls with mask and palette changes in flight
    errs = error_total();
    fork
      send_pixels(300);
      begin
        repeat (60) step_cycle();
        cpu_write(addr_mask, 8'h3f);
        check_byte(addr_mask, 8'h3f, "mask");
        cpu_write(addr_write_index, 8'h21);
        write_components(8'h21);
        repeat (120) step_cycle();
        cpu_write(addr_mask, 8'hff);
      end
    join
    while (received != sent)
      step_cycle();
    report_test("pixel_stream", errs);

    $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
             tests_run, tests_failed, mismatches, DUT.u_assert.fail_count);
    if (error_total() == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: sources.f
rtl/vga_dac_pkg.sv
rtl/vga_dac_regs.sv
rtl/vga_dac_port.sv
rtl/vga_dac_pixel_pipe.sv
rtl/vga_dac_top.sv
verif/vga_dac_assert.sv
verif/vga_dac_tb.sv

// File: Makefile
# Verilator build and run for the VGA palette block

SIM := obj_dir/Vvga_dac_tb

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a listed source changes
$(SIM): sources.f $(shell grep -v '^+' sources.f)
	verilator --binary --assert -Wno-fatal --top-module vga_dac_tb -f sources.f

# Pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
